// ==== src/gecko_pkg.sv ====
// shared widths, types and records of the fetch predictor; referenced by scoped names
package gecko_pkg;

    // address and table geometry
    localparam int PC_WIDTH = 32;
    localparam int TARGET_ADDR_WIDTH = 6;
    localparam int HISTORY_WIDTH = TARGET_ADDR_WIDTH;
    localparam int TAG_WIDTH = PC_WIDTH - TARGET_ADDR_WIDTH - 2;
    localparam int TABLE_DEPTH = 2 ** TARGET_ADDR_WIDTH;

    typedef logic [PC_WIDTH-1:0] pc_t;
    typedef logic [TARGET_ADDR_WIDTH-1:0] table_addr_t;
    typedef logic [TAG_WIDTH-1:0] tag_t;
    typedef logic [HISTORY_WIDTH-1:0] history_t;

    // 2-bit saturating counter, msb means taken
    typedef logic [1:0] counter_t;

    // weakly not taken
    localparam counter_t COUNTER_INIT = 2'b01;

    typedef enum logic {
        MODE_SIMPLE,
        MODE_GLOBAL
    } predictor_mode_t;

    typedef enum logic [1:0] {
        CLEAR_IDLE,
        CLEAR_SWEEP,
        CLEAR_DONE
    } clear_state_t;

    // resolved jump from execute
    typedef struct packed {
        pc_t current_pc;
        pc_t actual_next_pc;
        logic branched;
        logic jumped;
        logic mispredicted;
        counter_t history;
    } jump_command_t;

    // answer given to fetch in the lookup cycle
    typedef struct packed {
        logic valid;
        logic taken;
        pc_t target;
        counter_t history;
    } prediction_t;

endpackage

// ==== src/gecko_clear_fsm.sv ====
// sequences the post-reset table sweep and signals reset_done once both tables are clean
module gecko_clear_fsm (
    input  logic clk,
    input  logic rst,
    input  logic count_last,
    output logic clear_en,
    output logic count_en,
    output logic reset_done
);

    gecko_pkg::clear_state_t state, next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= gecko_pkg::CLEAR_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            gecko_pkg::CLEAR_IDLE:  next_state = gecko_pkg::CLEAR_SWEEP;
            gecko_pkg::CLEAR_SWEEP: if (count_last) next_state = gecko_pkg::CLEAR_DONE;
            gecko_pkg::CLEAR_DONE:  next_state = gecko_pkg::CLEAR_DONE;
            default:                next_state = gecko_pkg::CLEAR_IDLE;
        endcase
    end

    // one table entry written per sweep cycle
    assign clear_en = (state == gecko_pkg::CLEAR_SWEEP);
    assign count_en = (state == gecko_pkg::CLEAR_SWEEP);

    // registered, so it rises one cycle after the state reaches done
    always_ff @(posedge clk) begin
        if (rst) begin
            reset_done <= 1'b0;
        end else begin
            reset_done <= (state == gecko_pkg::CLEAR_DONE);
        end
    end

endmodule

// ==== src/gecko_clear_counter.sv ====
// steps the sweep index over every table entry and flags the final one
module gecko_clear_counter (
    input  logic clk,
    input  logic rst,
    input  logic count_en,
    output gecko_pkg::table_addr_t clear_addr,
    output logic count_last
);

    localparam gecko_pkg::table_addr_t LAST_ADDR =
        gecko_pkg::table_addr_t'(gecko_pkg::TABLE_DEPTH - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            clear_addr <= '0;
        end else if (count_en) begin
            // wraps back to zero after the last entry
            clear_addr <= clear_addr + 1'b1;
        end
    end

    assign count_last = (clear_addr == LAST_ADDR);

endmodule

// ==== src/gecko_target_table.sv ====
// tagged branch target table, looked up combinationally from fetch and written by execute
module gecko_target_table (
    input  logic clk,
    input  gecko_pkg::pc_t pc,
    input  logic update_en,
    input  gecko_pkg::jump_command_t jump,
    input  logic clear_en,
    input  gecko_pkg::table_addr_t clear_addr,
    output logic hit,
    output gecko_pkg::pc_t target,
    output logic jump_entry
);

    typedef struct packed {
        logic valid;
        gecko_pkg::tag_t tag;
        gecko_pkg::pc_t target;
        logic jump_instruction;
    } target_entry_t;

    target_entry_t entries [gecko_pkg::TABLE_DEPTH];

    gecko_pkg::table_addr_t read_idx;
    gecko_pkg::tag_t read_tag;
    target_entry_t read_entry;

    gecko_pkg::table_addr_t write_idx;
    target_entry_t write_entry;

    // index from pc[7:2], tag from the bits above
    assign read_idx = pc[gecko_pkg::TARGET_ADDR_WIDTH+1:2];
    assign read_tag = pc[gecko_pkg::PC_WIDTH-1:gecko_pkg::TARGET_ADDR_WIDTH+2];
    assign read_entry = entries[read_idx];

    // no hits while the sweep is still running
    assign hit = read_entry.valid && (read_entry.tag == read_tag) && !clear_en;
    assign target = read_entry.target;
    assign jump_entry = read_entry.jump_instruction;

    assign write_idx = jump.current_pc[gecko_pkg::TARGET_ADDR_WIDTH+1:2];

    always_comb begin
        write_entry.valid = 1'b1;
        write_entry.tag = jump.current_pc[gecko_pkg::PC_WIDTH-1:gecko_pkg::TARGET_ADDR_WIDTH+2];
        write_entry.target = jump.actual_next_pc;
        write_entry.jump_instruction = jump.jumped;
    end

    // single write port, the sweep wins over an update
    always_ff @(posedge clk) begin
        if (clear_en) begin
            entries[clear_addr] <= '0;
        end else if (update_en) begin
            entries[write_idx] <= write_entry;
        end
    end

endmodule

// ==== src/gecko_pattern_table.sv ====
// saturating counter table with global history; index source picked by the mode input
module gecko_pattern_table (
    input  logic clk,
    input  logic rst,
    input  gecko_pkg::predictor_mode_t mode,
    input  gecko_pkg::pc_t pc,
    input  logic update_en,
    input  gecko_pkg::jump_command_t jump,
    input  logic clear_en,
    input  gecko_pkg::table_addr_t clear_addr,
    output gecko_pkg::counter_t counter
);

    gecko_pkg::counter_t counters [gecko_pkg::TABLE_DEPTH];

    gecko_pkg::history_t global_history;
    gecko_pkg::table_addr_t read_idx;
    gecko_pkg::table_addr_t write_idx;
    gecko_pkg::counter_t write_value;

    // step toward taken or not taken, holding at both ends
    function automatic gecko_pkg::counter_t next_counter(
        input gecko_pkg::counter_t value,
        input logic taken
    );
        gecko_pkg::counter_t result;
        result = value;
        if (taken && value != 2'b11) begin
            result = value + 2'b01;
        end else if (!taken && value != 2'b00) begin
            result = value - 2'b01;
        end
        return result;
    endfunction

    always_comb begin
        if (mode == gecko_pkg::MODE_GLOBAL) begin
            read_idx = global_history;
            write_idx = global_history;
        end else begin
            read_idx = pc[gecko_pkg::TARGET_ADDR_WIDTH+1:2];
            write_idx = jump.current_pc[gecko_pkg::TARGET_ADDR_WIDTH+1:2];
        end
    end

    assign counter = counters[read_idx];

    // based on the counter reported with the original prediction
    assign write_value = next_counter(jump.history, jump.branched);

    always_ff @(posedge clk) begin
        if (clear_en) begin
            counters[clear_addr] <= gecko_pkg::COUNTER_INIT;
        end else if (update_en) begin
            counters[write_idx] <= write_value;
        end
    end

    // newest outcome enters at bit 0
    always_ff @(posedge clk) begin
        if (rst) begin
            global_history <= '0;
        end else if (update_en) begin
            global_history <= {global_history[gecko_pkg::HISTORY_WIDTH-2:0], jump.branched};
        end
    end

endmodule

// ==== src/gecko_fetch_predictor.sv ====
// fetch-stage branch predictor top; same-cycle prediction for pc, trained by resolved jumps
module gecko_fetch_predictor (
    input  logic clk,
    input  logic rst,
    input  gecko_pkg::predictor_mode_t mode,
    input  gecko_pkg::pc_t pc,
    input  logic jump_valid,
    input  gecko_pkg::jump_command_t jump,
    output gecko_pkg::prediction_t prediction,
    output logic reset_done
);

    logic clear_en;
    logic count_en;
    logic count_last;
    gecko_pkg::table_addr_t clear_addr;

    logic update_en;
    logic hit;
    gecko_pkg::pc_t target;
    logic jump_entry;
    gecko_pkg::counter_t counter;

    gecko_clear_fsm clear_fsm_inst (
        .clk        (clk),
        .rst        (rst),
        .count_last (count_last),
        .clear_en   (clear_en),
        .count_en   (count_en),
        .reset_done (reset_done)
    );

    gecko_clear_counter clear_counter_inst (
        .clk        (clk),
        .rst        (rst),
        .count_en   (count_en),
        .clear_addr (clear_addr),
        .count_last (count_last)
    );

    // mispredicted jumps and anything before the sweep ends are dropped
    assign update_en = jump_valid && !jump.mispredicted && reset_done;

    gecko_target_table target_table_inst (
        .clk        (clk),
        .pc         (pc),
        .update_en  (update_en),
        .jump       (jump),
        .clear_en   (clear_en),
        .clear_addr (clear_addr),
        .hit        (hit),
        .target     (target),
        .jump_entry (jump_entry)
    );

    gecko_pattern_table pattern_table_inst (
        .clk        (clk),
        .rst        (rst),
        .mode       (mode),
        .pc         (pc),
        .update_en  (update_en),
        .jump       (jump),
        .clear_en   (clear_en),
        .clear_addr (clear_addr),
        .counter    (counter)
    );

    // unconditional jumps are always predicted taken
    assign prediction.valid = hit;
    assign prediction.taken = counter[1] || jump_entry;
    assign prediction.target = target;
    assign prediction.history = counter;

endmodule

// ==== tb/gecko_fetch_predictor_tb.sv ====
// self-checking testbench for the fetch predictor; random lookups and jumps against a table model
module gecko_fetch_predictor_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int SWEEP_CYCLES = 65;
    localparam int PHASE_CYCLES = 2000;
    localparam int POOL_SIZE = 16;
    localparam int WATCHDOG_CYCLES =
        2 * (RESET_CYCLES + SWEEP_CYCLES) + 2 * PHASE_CYCLES + 100;

    logic clk;
    logic rst;
    gecko_pkg::predictor_mode_t mode;
    gecko_pkg::pc_t pc;
    logic jump_valid;
    gecko_pkg::jump_command_t jump;
    gecko_pkg::prediction_t prediction;
    logic reset_done;

    // reference model of both tables and the history register
    logic model_valid [gecko_pkg::TABLE_DEPTH];
    gecko_pkg::tag_t model_tag [gecko_pkg::TABLE_DEPTH];
    gecko_pkg::pc_t model_target [gecko_pkg::TABLE_DEPTH];
    logic model_jump [gecko_pkg::TABLE_DEPTH];
    gecko_pkg::counter_t model_counter [gecko_pkg::TABLE_DEPTH];
    gecko_pkg::history_t model_history;

    // edges seen with rst low, saturating once reset_done is due
    int low_edges;

    gecko_pkg::pc_t pc_pool [POOL_SIZE];
    gecko_pkg::counter_t last_counter [POOL_SIZE];
    int pc_sel;
    logic [31:0] rng_state;
    int error_count;

    gecko_fetch_predictor UUT (
        .clk        (clk),
        .rst        (rst),
        .mode       (mode),
        .pc         (pc),
        .jump_valid (jump_valid),
        .jump       (jump),
        .prediction (prediction),
        .reset_done (reset_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the test did not reach its end within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 2-bit counter, one step toward the outcome, held at 0 and 3
    function automatic gecko_pkg::counter_t saturate_step(
        input gecko_pkg::counter_t c,
        input logic taken
    );
        gecko_pkg::counter_t n;
        case ({taken, c})
            3'b1_11: n = 2'b11;
            3'b0_00: n = 2'b00;
            default: n = taken ? c + 2'd1 : c - 2'd1;
        endcase
        return n;
    endfunction

    task automatic check_value(
        input string name,
        input logic [63:0] expected,
        input logic [63:0] actual
    );
        if (actual !== expected) begin
            error_count++;
            $display("ERROR time %0d ns: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic clear_model();
        for (int i = 0; i < gecko_pkg::TABLE_DEPTH; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i] = '0;
            model_target[i] = '0;
            model_jump[i] = 1'b0;
            model_counter[i] = gecko_pkg::COUNTER_INIT;
        end
    endtask

    // state change at one rising edge, from the inputs held before it
    task automatic model_edge();
        gecko_pkg::table_addr_t idx;
        gecko_pkg::table_addr_t ctr_idx;
        logic accepted;
        accepted = jump_valid && !jump.mispredicted && (low_edges > SWEEP_CYCLES);
        idx = jump.current_pc[7:2];
        ctr_idx = (mode == gecko_pkg::MODE_GLOBAL) ? model_history : idx;
        if (accepted) begin
            model_valid[idx] = 1'b1;
            model_tag[idx] = jump.current_pc[31:8];
            model_target[idx] = jump.actual_next_pc;
            model_jump[idx] = jump.jumped;
            model_counter[ctr_idx] = saturate_step(jump.history, jump.branched);
        end
        if (rst) begin
            model_history = '0;
            low_edges = 0;
        end else begin
            if (accepted) begin
                model_history = {model_history[gecko_pkg::HISTORY_WIDTH-2:0], jump.branched};
            end
            if (low_edges <= SWEEP_CYCLES) begin
                low_edges++;
            end
            // last sweep write lands on this edge
            if (low_edges == SWEEP_CYCLES) begin
                clear_model();
            end
        end
    endtask

    task automatic drive_inputs(
        input logic rst_value,
        input gecko_pkg::predictor_mode_t mode_value
    );
        logic [31:0] r_pc;
        logic [31:0] r_jump;
        logic [31:0] r_target;
        int jump_sel;
        gecko_pkg::jump_command_t cmd;
        rng_state = xorshift32(rng_state);
        r_pc = rng_state;
        rng_state = xorshift32(rng_state);
        r_jump = rng_state;
        rng_state = xorshift32(rng_state);
        r_target = rng_state;
        pc_sel = int'(r_pc[3:0]);
        jump_sel = int'(r_jump[7:4]);
        cmd.current_pc = pc_pool[jump_sel];
        cmd.actual_next_pc = {r_target[31:2], 2'b00};
        cmd.branched = r_jump[1];
        cmd.jumped = r_jump[2] & r_jump[8];
        cmd.mispredicted = r_jump[3];
        // counter seen at the last lookup of that pc
        cmd.history = last_counter[jump_sel];
        rst <= rst_value;
        mode <= mode_value;
        pc <= pc_pool[pc_sel];
        jump_valid <= r_jump[0];
        jump <= cmd;
    endtask

    task automatic check_outputs();
        gecko_pkg::table_addr_t idx;
        gecko_pkg::counter_t ctr;
        logic exp_valid;
        check_value("reset_done", 64'(low_edges > SWEEP_CYCLES), 64'(reset_done));
        if (low_edges >= 1 && low_edges <= SWEEP_CYCLES) begin
            check_value("prediction.valid", 64'(1'b0), 64'(prediction.valid));
        end
        if (low_edges >= SWEEP_CYCLES) begin
            idx = pc[7:2];
            if (mode == gecko_pkg::MODE_GLOBAL) begin
                ctr = model_counter[model_history];
            end else begin
                ctr = model_counter[idx];
            end
            exp_valid = model_valid[idx] && (model_tag[idx] == pc[31:8]);
            check_value("prediction.valid", 64'(exp_valid), 64'(prediction.valid));
            check_value("prediction.taken", 64'(ctr[1] || model_jump[idx]),
                        64'(prediction.taken));
            check_value("prediction.target", 64'(model_target[idx]), 64'(prediction.target));
            check_value("prediction.history", 64'(ctr), 64'(prediction.history));
            last_counter[pc_sel] = prediction.history;
        end
    endtask

    task automatic run_cycle(
        input logic rst_value,
        input gecko_pkg::predictor_mode_t mode_value
    );
        @(posedge clk);
        model_edge();
        drive_inputs(rst_value, mode_value);
        @(negedge clk);
        check_outputs();
    endtask

    // reset, sweep, then random traffic in one mode
    task automatic run_phase(input gecko_pkg::predictor_mode_t mode_value);
        repeat (RESET_CYCLES) begin
            run_cycle(1'b1, mode_value);
        end
        repeat (SWEEP_CYCLES + 1 + PHASE_CYCLES) begin
            run_cycle(1'b0, mode_value);
        end
    endtask

    initial begin
        rst = 1'b1;
        mode = gecko_pkg::MODE_SIMPLE;
        pc = '0;
        jump_valid = 1'b0;
        jump = '0;
        rng_state = 32'h3bc2;
        error_count = 0;
        low_edges = 0;
        model_history = '0;
        pc_sel = 0;
        clear_model();

        // six indices shared by up to three tags each
        for (int i = 0; i < POOL_SIZE; i++) begin
            pc_pool[i] = {gecko_pkg::tag_t'(24'h000400 + i / 6),
                          gecko_pkg::table_addr_t'(i % 6), 2'b00};
            last_counter[i] = gecko_pkg::COUNTER_INIT;
        end

        run_phase(gecko_pkg::MODE_SIMPLE);
        run_phase(gecko_pkg::MODE_GLOBAL);

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
src/gecko_pkg.sv
src/gecko_clear_fsm.sv
src/gecko_clear_counter.sv
src/gecko_target_table.sv
src/gecko_pattern_table.sv
src/gecko_fetch_predictor.sv
tb/gecko_fetch_predictor_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the fetch predictor testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module gecko_fetch_predictor_tb \
    -Mdir obj_dir \
    -f tb.f

output=$(./obj_dir/Vgecko_fetch_predictor_tb)
echo "$output"

if grep -qx "STATUS: PASS" <<< "$output"; then
    exit 0
else
    exit 1
fi
